// File: vlog.f
verilog/csr_index_pkg.sv
verilog/csr_cfg_if.sv
verilog/csr_response_router.sv
verilog/csr_index_configure.sv
verilog/csr_index_generator.sv
verilog/csr_index_engine.sv
verification/csr_index_checker.sv
verification/csr_index_tb.sv

// File: Makefile
# Verilator build and run of the CSR index engine testbench
# Every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= csr_index_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= ** FAIL **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) from $(FILELIST), run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/csr_index_tb.sv
// Testbench top with clock, reset, job table, stimulus loop, memory responder and watchdog
`timescale 1ns/100ps

module csr_index_tb
    import csr_index_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 5;
    localparam int NUM_JOBS       = 6;
    localparam int MAX_RESP_DELAY = 8;
    localparam int IDLE_CYCLES    = 6;
    localparam int JUNK_DELAY     = 6;

    // One job per row
    typedef struct packed {
        logic [31:0] base;
        logic [15:0] first;
        logic [15:0] count;
        logic [7:0]  stall_pct;
        logic [1:0]  junk_dest;
        logic        count_first;
    } job_t;

    // Descriptor or response waiting to be driven
    typedef struct packed {
        logic                  is_desc;
        logic [DEST_WIDTH-1:0] dest;
        resp_op_e              op;
        logic [DATA_WIDTH-1:0] data;
    } cmd_t;

    logic                  ap_clk            = 1'b0;
    logic                  areset_csr_engine = 1'b1;
    logic                  resp_valid_i      = 1'b0;
    logic [DEST_WIDTH-1:0] resp_dest_i       = '0;
    resp_op_e              resp_op_i         = OP_CFG_FIRST;
    logic [DATA_WIDTH-1:0] resp_data_i       = '0;
    logic                  desc_valid_i      = 1'b0;
    logic [ADDR_WIDTH-1:0] desc_base_i       = '0;
    logic                  req_ready_i       = 1'b1;
    logic                  req_valid_o;
    logic [ADDR_WIDTH-1:0] req_addr_o;
    logic                  done_o;

    job_t   job_table [NUM_JOBS];
    logic   table_loaded = 1'b0;
    cmd_t   cmd_q [$];
    int     data_due [$];
    int     cycle_count = 0;
    int     stall_pct = 0;
    logic [15:0] resp_seq = '0;
    integer seed = 32'h240e6e17;
    int     tests_done;
    int     tests_failed;
    int     error_count;

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    csr_index_engine u_dut (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .resp_valid_i     (resp_valid_i),
        .resp_dest_i      (resp_dest_i),
        .resp_op_i        (resp_op_i),
        .resp_data_i      (resp_data_i),
        .desc_valid_i     (desc_valid_i),
        .desc_base_i      (desc_base_i),
        .req_ready_i      (req_ready_i),
        .req_valid_o      (req_valid_o),
        .req_addr_o       (req_addr_o),
        .done_o           (done_o)
    );

    csr_index_checker u_checker (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .resp_valid_i     (resp_valid_i),
        .resp_dest_i      (resp_dest_i),
        .resp_op_i        (resp_op_i),
        .resp_data_i      (resp_data_i),
        .desc_valid_i     (desc_valid_i),
        .desc_base_i      (desc_base_i),
        .req_valid_i      (req_valid_o),
        .req_addr_i       (req_addr_o),
        .done_i           (done_o),
        .tests_done_o     (tests_done),
        .tests_failed_o   (tests_failed),
        .error_count_o    (error_count)
    );

    task automatic queue_descriptor(input logic [ADDR_WIDTH-1:0] base);
        cmd_q.push_back('{1'b1, DEST_CONFIGURE, OP_CFG_FIRST, base});
    endtask

    task automatic queue_response(input logic [DEST_WIDTH-1:0] dest, input resp_op_e op,
                                  input logic [DATA_WIDTH-1:0] data);
        cmd_q.push_back('{1'b0, dest, op, data});
    endtask

    // Junk that would corrupt the count or the configuration if misrouted
    task automatic queue_junk(input logic [1:0] dest);
        if (dest == 2'd3) begin
            queue_response(dest, OP_CFG_COUNT, 32'h0000_0033);
        end else begin
            queue_response(dest, OP_DATA, 32'hbad0_0001);
        end
    endtask

    function automatic int job_cycle_budget(input job_t job);
        int issue_cycles;
        issue_cycles = int'(job.count) * 100 / (100 - int'(job.stall_pct));
        return issue_cycles + int'(job.count) + MAX_RESP_DELAY + IDLE_CYCLES + 40;
    endfunction

    // ----------------------------------------------------------------------
    // Responder and ready generator, all inputs change on the falling edge
    // ----------------------------------------------------------------------
    always @(negedge ap_clk) begin
        cmd_t cmd;
        int   roll;
        cycle_count = cycle_count + 1;
        roll        = $unsigned($random(seed)) % 100;
        req_ready_i = (roll >= stall_pct);
        if (req_valid_o === 1'b1) begin
            roll = $unsigned($random(seed)) % (MAX_RESP_DELAY + 1);
            data_due.push_back(cycle_count + roll);
        end
        desc_valid_i = 1'b0;
        resp_valid_i = 1'b0;
        if (cmd_q.size() > 0) begin
            cmd = cmd_q.pop_front();
            if (cmd.is_desc) begin
                desc_valid_i = 1'b1;
                desc_base_i  = cmd.data;
            end else begin
                resp_valid_i = 1'b1;
                resp_dest_i  = cmd.dest;
                resp_op_i    = cmd.op;
                resp_data_i  = cmd.data;
            end
        end else if (data_due.size() > 0 && data_due[0] <= cycle_count) begin
            void'(data_due.pop_front());
            resp_valid_i = 1'b1;
            resp_dest_i  = DEST_GENERATOR;
            resp_op_i    = OP_DATA;
            resp_data_i  = {16'hda7a, resp_seq};
            resp_seq     = resp_seq + 16'd1;
        end
    end

    // Watchdog sized from the job table
    initial begin
        int limit;
        wait (table_loaded);
        limit = RESET_CYCLES + 20;
        for (int i = 0; i < NUM_JOBS; i++) begin
            limit = limit + 2 * job_cycle_budget(job_table[i]);
        end
        #(limit * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a job never reached done_o", limit);
        $display("** FAIL **");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Job table and main loop
    // ----------------------------------------------------------------------
    initial begin
        job_t job;
        //               base          first      count   stall junk  count first
        job_table[0] = '{32'h1000_0000, 16'd0,     16'd8,  8'd0,  2'd2, 1'b0};
        job_table[1] = '{32'h2000_0040, 16'd5,     16'd12, 8'd40, 2'd0, 1'b1};
        job_table[2] = '{32'h0000_8000, 16'd100,   16'd0,  8'd0,  2'd3, 1'b0};
        job_table[3] = '{32'h3fff_fff0, 16'd1000,  16'd20, 8'd70, 2'd2, 1'b1};
        job_table[4] = '{32'h0001_0000, 16'd65530, 16'd4,  8'd20, 2'd0, 1'b0};
        job_table[5] = '{32'ha000_0004, 16'd7,     16'd1,  8'd50, 2'd3, 1'b1};
        table_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_csr_engine = 1'b0;
        // Outputs must stay quiet while no job runs
        repeat (IDLE_CYCLES) @(posedge ap_clk);

        for (int r = 0; r < NUM_JOBS; r++) begin
            job = job_table[r];
            @(posedge ap_clk);
            stall_pct = int'(job.stall_pct);
            queue_descriptor(job.base);
            if (job.count_first) begin
                queue_response(DEST_CONFIGURE, OP_CFG_COUNT, {16'h0000, job.count});
                if (job.junk_dest == 2'd3) begin
                    queue_junk(job.junk_dest);
                end
                queue_response(DEST_CONFIGURE, OP_CFG_FIRST, {16'h0000, job.first});
            end else begin
                queue_response(DEST_CONFIGURE, OP_CFG_FIRST, {16'h0000, job.first});
                if (job.junk_dest == 2'd3) begin
                    queue_junk(job.junk_dest);
                end
                queue_response(DEST_CONFIGURE, OP_CFG_COUNT, {16'h0000, job.count});
            end
            // Data junk lands after the handover while returns are counted
            if (job.junk_dest != 2'd3) begin
                repeat (JUNK_DELAY) @(posedge ap_clk);
                queue_junk(job.junk_dest);
            end
            wait (tests_done >= r + 1);
            // Done must hold and no request may follow
            repeat (IDLE_CYCLES) @(posedge ap_clk);
        end

        @(negedge ap_clk);
        $display("Jobs run %0d, passed %0d, failed %0d, errors %0d",
                 tests_done, tests_done - tests_failed, tests_failed, error_count);
        if (error_count == 0 && tests_done == NUM_JOBS) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : csr_index_tb

// File: verification/csr_index_checker.sv
// Port monitor that predicts request addresses and done timing, and reports per-job results
`timescale 1ns/100ps

module csr_index_checker
    import csr_index_pkg::*;
(
    input  logic                  ap_clk,
    input  logic                  areset_csr_engine,
    input  logic                  resp_valid_i,
    input  logic [DEST_WIDTH-1:0] resp_dest_i,
    input  resp_op_e              resp_op_i,
    input  logic [DATA_WIDTH-1:0] resp_data_i,
    input  logic                  desc_valid_i,
    input  logic [ADDR_WIDTH-1:0] desc_base_i,
    input  logic                  req_valid_i,
    input  logic [ADDR_WIDTH-1:0] req_addr_i,
    input  logic                  done_i,
    output int                    tests_done_o,
    output int                    tests_failed_o,
    output int                    error_count_o
);

    // Index entries are 4 bytes
    localparam int ADDR_SHIFT = 2;
    // Input register, router, return counter, FSM and output register each add a cycle
    localparam int DONE_LATENCY = 5;

    logic [ADDR_WIDTH-1:0]  exp_base;
    logic [INDEX_WIDTH-1:0] exp_first;
    logic [INDEX_WIDTH-1:0] exp_count;
    int   req_seen;
    int   data_seen;
    int   job_errors;
    int   sample_count     = 0;
    int   last_data_sample = 0;
    logic job_started     = 1'b0;
    logic desc_since_done = 1'b0;
    logic idle_reported   = 1'b0;
    logic done_q          = 1'b0;

    initial begin
        tests_done_o   = 0;
        tests_failed_o = 0;
        error_count_o  = 0;
    end

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0d ns: %s", $time, msg);
        error_count_o = error_count_o + 1;
        job_errors    = job_errors + 1;
    endtask

    task automatic report_problem(input string msg);
        $display("At %0d ns %s", $time, msg);
        error_count_o = error_count_o + 1;
        job_errors    = job_errors + 1;
    endtask

    always @(posedge ap_clk) begin
        logic [INDEX_WIDTH-1:0] idx;
        logic [ADDR_WIDTH-1:0]  exp_addr;
        sample_count = sample_count + 1;
        if (areset_csr_engine) begin
            done_q = 1'b0;
        end else begin
            // Quiet outputs are expected until the first descriptor
            if (!job_started && !idle_reported && (req_valid_i !== 1'b0 || done_i !== 1'b0)) begin
                report_problem("the DUT raised req_valid_o or done_o before any job was started");
                idle_reported = 1'b1;
            end
            if (desc_valid_i) begin
                exp_base        = desc_base_i;
                req_seen        = 0;
                data_seen       = 0;
                job_errors      = 0;
                job_started     = 1'b1;
                desc_since_done = 1'b1;
            end
            // Decode responses by the routing rules
            if (resp_valid_i) begin
                if (resp_dest_i == DEST_CONFIGURE && resp_op_i == OP_CFG_FIRST) begin
                    exp_first = resp_data_i[INDEX_WIDTH-1:0];
                end
                if (resp_dest_i == DEST_CONFIGURE && resp_op_i == OP_CFG_COUNT) begin
                    exp_count = resp_data_i[INDEX_WIDTH-1:0];
                end
                if (resp_dest_i == DEST_GENERATOR && resp_op_i == OP_DATA) begin
                    data_seen        = data_seen + 1;
                    last_data_sample = sample_count;
                end
            end
            if (req_valid_i === 1'b1) begin
                if (req_seen >= int'(exp_count)) begin
                    report_problem($sformatf("the DUT issued an extra request to %h", req_addr_i));
                end else begin
                    idx      = exp_first + INDEX_WIDTH'(req_seen);
                    exp_addr = exp_base + (ADDR_WIDTH'(idx) << ADDR_SHIFT);
                    if (req_addr_i !== exp_addr) begin
                        report_mismatch($sformatf("request %0d address %h, expected %h",
                                                  req_seen, req_addr_i, exp_addr));
                    end
                end
                req_seen = req_seen + 1;
            end
            // Job ends on the rising edge of done
            if (done_i === 1'b1 && !done_q) begin
                if (!desc_since_done) begin
                    report_problem("done_o rose without a new descriptor");
                end
                if (req_seen != int'(exp_count) || data_seen != int'(exp_count)) begin
                    report_mismatch($sformatf("done with %0d requests and %0d returns, expected %0d",
                                              req_seen, data_seen, exp_count));
                end
                // The last return must have had time to reach the return counter
                if (data_seen > 0 && (sample_count - last_data_sample) < DONE_LATENCY) begin
                    report_mismatch($sformatf("done %0d cycles after the last return, expected %0d",
                                              sample_count - last_data_sample, DONE_LATENCY));
                end
                tests_done_o = tests_done_o + 1;
                if (job_errors != 0) begin
                    tests_failed_o = tests_failed_o + 1;
                end
                $display("Job %0d: base %h first %0d count %0d, %0d requests, %0s",
                         tests_done_o, exp_base, exp_first, exp_count, req_seen,
                         (job_errors == 0) ? "ok" : "with errors");
                desc_since_done = 1'b0;
            end
            if (done_i !== 1'b1 && done_q && !desc_since_done) begin
                report_problem("done_o dropped before the next descriptor arrived");
            end
            done_q = (done_i === 1'b1);
        end
    end

endmodule : csr_index_checker

// File: verilog/csr_index_engine.sv
// CSR index engine top level with input and output registers and block instances
`timescale 1ns/100ps

module csr_index_engine
    import csr_index_pkg::*;
#(
    parameter int ADDR_WIDTH  = csr_index_pkg::ADDR_WIDTH,
    parameter int INDEX_WIDTH = csr_index_pkg::INDEX_WIDTH
) (
    input  logic                  ap_clk,
    input  logic                  areset_csr_engine,
    input  logic                  resp_valid_i,
    input  logic [DEST_WIDTH-1:0] resp_dest_i,
    input  resp_op_e              resp_op_i,
    input  logic [DATA_WIDTH-1:0] resp_data_i,
    input  logic                  desc_valid_i,
    input  logic [ADDR_WIDTH-1:0] desc_base_i,
    input  logic                  req_ready_i,
    output logic                  req_valid_o,
    output logic [ADDR_WIDTH-1:0] req_addr_o,
    output logic                  done_o
);

    logic                  resp_valid_q;
    logic [DEST_WIDTH-1:0] resp_dest_q;
    resp_op_e              resp_op_q;
    logic [DATA_WIDTH-1:0] resp_data_q;
    logic                  desc_valid_q;
    logic [ADDR_WIDTH-1:0] desc_base_q;
    logic                  req_ready_q;

    logic                  cfg_word_valid;
    resp_op_e              cfg_word_op;
    logic [DATA_WIDTH-1:0] cfg_word_data;
    logic                  data_valid;
    logic                  gen_req_valid;
    logic [ADDR_WIDTH-1:0] gen_req_addr;
    logic                  gen_done;

    // ----------------------------------------------------------------------
    // Input registers
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            resp_valid_q <= 1'b0;
            desc_valid_q <= 1'b0;
            req_ready_q  <= 1'b0;
        end else begin
            resp_valid_q <= resp_valid_i;
            desc_valid_q <= desc_valid_i;
            req_ready_q  <= req_ready_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        resp_dest_q <= resp_dest_i;
        resp_op_q   <= resp_op_i;
        resp_data_q <= resp_data_i;
        desc_base_q <= desc_base_i;
    end

    // ----------------------------------------------------------------------
    // Output registers
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            req_valid_o <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            req_valid_o <= gen_req_valid;
            done_o      <= gen_done;
        end
    end

    always_ff @(posedge ap_clk) begin
        req_addr_o <= gen_req_addr;
    end

    // ----------------------------------------------------------------------
    // Response router, configuration and generator
    // ----------------------------------------------------------------------
    csr_cfg_if #(
        .INDEX_WIDTH(INDEX_WIDTH)
    ) u_cfg_if ();

    csr_response_router u_router (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .resp_valid_i     (resp_valid_q),
        .resp_dest_i      (resp_dest_q),
        .resp_op_i        (resp_op_q),
        .resp_data_i      (resp_data_q),
        .cfg_word_valid_o (cfg_word_valid),
        .cfg_word_op_o    (cfg_word_op),
        .cfg_word_data_o  (cfg_word_data),
        .data_valid_o     (data_valid)
    );

    csr_index_configure #(
        .INDEX_WIDTH(INDEX_WIDTH)
    ) u_configure (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .cfg_word_valid_i (cfg_word_valid),
        .cfg_word_op_i    (cfg_word_op),
        .cfg_word_data_i  (cfg_word_data),
        .cfg              (u_cfg_if.configure)
    );

    csr_index_generator #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .INDEX_WIDTH(INDEX_WIDTH)
    ) u_generator (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .desc_valid_i     (desc_valid_q),
        .desc_base_i      (desc_base_q),
        .req_ready_i      (req_ready_q),
        .data_valid_i     (data_valid),
        .cfg              (u_cfg_if.generator),
        .req_valid_o      (gen_req_valid),
        .req_addr_o       (gen_req_addr),
        .gen_done_o       (gen_done)
    );

endmodule : csr_index_engine

// File: verilog/csr_index_generator.sv
// Index read request FSM with back-pressure handling and data return counting
`timescale 1ns/100ps

module csr_index_generator
    import csr_index_pkg::*;
#(
    parameter int ADDR_WIDTH  = csr_index_pkg::ADDR_WIDTH,
    parameter int INDEX_WIDTH = csr_index_pkg::INDEX_WIDTH
) (
    input  logic                  ap_clk,
    input  logic                  areset_csr_engine,
    input  logic                  desc_valid_i,
    input  logic [ADDR_WIDTH-1:0] desc_base_i,
    input  logic                  req_ready_i,
    input  logic                  data_valid_i,
    csr_cfg_if.generator          cfg,
    output logic                  req_valid_o,
    output logic [ADDR_WIDTH-1:0] req_addr_o,
    output logic                  gen_done_o
);

    gen_state_e state_q;
    gen_state_e state_d;

    logic [ADDR_WIDTH-1:0]  base_q;
    logic [INDEX_WIDTH-1:0] idx_q;
    logic [INDEX_WIDTH-1:0] left_q;
    logic [INDEX_WIDTH-1:0] count_q;
    logic [INDEX_WIDTH-1:0] ret_q;

    logic job_start;
    logic cfg_seen;
    logic issue;

    // ----------------------------------------------------------------------
    // Control strobes
    // ----------------------------------------------------------------------
    // A new descriptor is only taken while idle or holding done
    assign job_start = desc_valid_i && ((state_q == GEN_IDLE) || (state_q == GEN_DONE));
    assign cfg_seen  = (state_q == GEN_WAIT_CFG) && cfg.cfg_valid;
    // Low ready holds the current index
    assign issue     = (state_q == GEN_ISSUE) && req_ready_i;

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            GEN_IDLE, GEN_DONE: begin
                if (desc_valid_i) begin
                    state_d = GEN_WAIT_CFG;
                end
            end
            GEN_WAIT_CFG: begin
                if (cfg.cfg_valid) begin
                    // Empty job has nothing to issue or wait for
                    state_d = (cfg.cfg_count == '0) ? GEN_DONE : GEN_ISSUE;
                end
            end
            GEN_ISSUE: begin
                if (issue && (left_q == INDEX_WIDTH'(1))) begin
                    state_d = GEN_DRAIN;
                end
            end
            GEN_DRAIN: begin
                if (ret_q == count_q) begin
                    state_d = GEN_DONE;
                end
            end
            default: begin
                state_d = GEN_IDLE;
            end
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state_q <= GEN_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------------------------------------
    // Data return counter
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            ret_q <= '0;
        end else if (cfg_seen) begin
            ret_q <= '0;
        end else if (data_valid_i) begin
            ret_q <= ret_q + INDEX_WIDTH'(1);
        end
    end

    // ----------------------------------------------------------------------
    // Job registers
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (job_start) begin
            base_q <= desc_base_i;
        end
        if (cfg_seen) begin
            idx_q   <= cfg.cfg_first;
            left_q  <= cfg.cfg_count;
            count_q <= cfg.cfg_count;
        end else if (issue) begin
            idx_q  <= idx_q + INDEX_WIDTH'(1);
            left_q <= left_q - INDEX_WIDTH'(1);
        end
    end

    // Handover pulse in the same cycle that cfg_valid is seen
    assign cfg.cfg_taken = cfg_seen;

    // Byte address of the current index entry
    assign req_valid_o = issue;
    assign req_addr_o  = base_q + (ADDR_WIDTH'(idx_q) << INDEX_BYTES_LOG2);
    assign gen_done_o  = (state_q == GEN_DONE);

endmodule : csr_index_generator

// File: verilog/csr_index_configure.sv
// Configuration word collector that builds the held first-index and count configuration
`timescale 1ns/100ps

module csr_index_configure
    import csr_index_pkg::*;
#(
    parameter int INDEX_WIDTH = csr_index_pkg::INDEX_WIDTH
) (
    input  logic                  ap_clk,
    input  logic                  areset_csr_engine,
    input  logic                  cfg_word_valid_i,
    input  resp_op_e              cfg_word_op_i,
    input  logic [DATA_WIDTH-1:0] cfg_word_data_i,
    csr_cfg_if.configure          cfg
);

    logic [INDEX_WIDTH-1:0] first_q;
    logic [INDEX_WIDTH-1:0] count_q;
    logic                   have_first_q;
    logic                   have_count_q;
    logic                   take_first;
    logic                   take_count;

    assign take_first = cfg_word_valid_i && (cfg_word_op_i == OP_CFG_FIRST);
    assign take_count = cfg_word_valid_i && (cfg_word_op_i == OP_CFG_COUNT);

    // ----------------------------------------------------------------------
    // Received flags
    // ----------------------------------------------------------------------
    // A handover clears both flags; a word landing in the same cycle
    // starts the next configuration
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            have_first_q <= 1'b0;
            have_count_q <= 1'b0;
        end else begin
            if (cfg.cfg_taken) begin
                have_first_q <= 1'b0;
                have_count_q <= 1'b0;
            end
            if (take_first) begin
                have_first_q <= 1'b1;
            end
            if (take_count) begin
                have_count_q <= 1'b1;
            end
        end
    end

    // Held values survive the handover
    always_ff @(posedge ap_clk) begin
        if (take_first) begin
            first_q <= cfg_word_data_i[INDEX_WIDTH-1:0];
        end
        if (take_count) begin
            count_q <= cfg_word_data_i[INDEX_WIDTH-1:0];
        end
    end

    // Either word order works, valid rises once both have arrived
    assign cfg.cfg_valid = have_first_q && have_count_q;
    assign cfg.cfg_first = first_q;
    assign cfg.cfg_count = count_q;

endmodule : csr_index_configure

// File: verilog/csr_response_router.sv
// Registered 1-to-2 response router that steers by destination field and opcode
`timescale 1ns/100ps

module csr_response_router
    import csr_index_pkg::*;
(
    input  logic                  ap_clk,
    input  logic                  areset_csr_engine,
    input  logic                  resp_valid_i,
    input  logic [DEST_WIDTH-1:0] resp_dest_i,
    input  resp_op_e              resp_op_i,
    input  logic [DATA_WIDTH-1:0] resp_data_i,
    output logic                  cfg_word_valid_o,
    output resp_op_e              cfg_word_op_o,
    output logic [DATA_WIDTH-1:0] cfg_word_data_o,
    output logic                  data_valid_o
);

    logic to_configure;
    logic to_generator;

    // ----------------------------------------------------------------------
    // Steering decision
    // ----------------------------------------------------------------------
    // Only configuration opcodes are accepted by the configuration block
    assign to_configure = resp_valid_i && (resp_dest_i == DEST_CONFIGURE) &&
                          ((resp_op_i == OP_CFG_FIRST) || (resp_op_i == OP_CFG_COUNT));

    // Generator only counts data returns
    assign to_generator = resp_valid_i && (resp_dest_i == DEST_GENERATOR) &&
                          (resp_op_i == OP_DATA);

    // ----------------------------------------------------------------------
    // Output stage
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            cfg_word_valid_o <= 1'b0;
            data_valid_o     <= 1'b0;
        end else begin
            cfg_word_valid_o <= to_configure;
            data_valid_o     <= to_generator;
        end
    end

    // Word payload follows the strobe, qualified downstream by cfg_word_valid_o
    always_ff @(posedge ap_clk) begin
        cfg_word_op_o   <= resp_op_i;
        cfg_word_data_o <= resp_data_i;
    end

endmodule : csr_response_router

// File: verilog/csr_cfg_if.sv
// Held index configuration link from the configuration block to the generator
`timescale 1ns/100ps

interface csr_cfg_if
    import csr_index_pkg::*;
#(
    parameter int INDEX_WIDTH = csr_index_pkg::INDEX_WIDTH
) ();

    // Level, high while a complete configuration is held
    logic                   cfg_valid;
    logic [INDEX_WIDTH-1:0] cfg_first;
    logic [INDEX_WIDTH-1:0] cfg_count;
    // One-cycle pulse from the generator when it latches the configuration
    logic                   cfg_taken;

    modport configure (
        output cfg_valid,
        output cfg_first,
        output cfg_count,
        input  cfg_taken
    );

    modport generator (
        input  cfg_valid,
        input  cfg_first,
        input  cfg_count,
        output cfg_taken
    );

endinterface : csr_cfg_if

// File: verilog/csr_index_pkg.sv
// Shared widths, response destination codes, response opcode and generator state enums
package csr_index_pkg;

    // ----------------------------------------------------------------------
    // Datapath widths
    // ----------------------------------------------------------------------
    // Request address and descriptor base
    localparam int ADDR_WIDTH  = 32;
    // First index and index count
    localparam int INDEX_WIDTH = 16;
    // Response data word
    localparam int DATA_WIDTH  = 32;

    // Each index entry is 4 bytes wide
    localparam int INDEX_BYTES_LOG2 = 2;

    // ----------------------------------------------------------------------
    // Response routing
    // ----------------------------------------------------------------------
    localparam int DEST_WIDTH = 2;

    // Any other destination code is dropped by the router
    localparam logic [DEST_WIDTH-1:0] DEST_CONFIGURE = 2'd0;
    localparam logic [DEST_WIDTH-1:0] DEST_GENERATOR = 2'd1;

    // Response opcodes
    typedef enum logic [1:0] {
        OP_CFG_FIRST = 2'd0,
        OP_CFG_COUNT = 2'd1,
        OP_DATA      = 2'd2
    } resp_op_e;

    // Index generator FSM states
    typedef enum logic [2:0] {
        GEN_IDLE     = 3'd0,
        GEN_WAIT_CFG = 3'd1,
        GEN_ISSUE    = 3'd2,
        GEN_DRAIN    = 3'd3,
        GEN_DONE     = 3'd4
    } gen_state_e;

endpackage : csr_index_pkg
